//--- all.f
+incdir+.
gpu_pkg.sv
commit_if.sv
writeback_if.sv
commit_arb.sv
commit_stage.sv
warp_regfile.sv
commit_top.sv
tb_clock_gen.sv
tb_commit.sv

//--- commit_arb.sv
/* fixed-priority stream arbiter for one issue slot
   lowest valid input wins, result held in an output register */

`default_nettype none

`include "gpu_consts.svh"

module commit_arb import gpu_pkg::*; #(
    parameter int NUM_INPUTS = `NUM_EX_UNITS
) (
    input  logic                            clk,
    input  logic                            rst_n,

    input  logic     [NUM_INPUTS-1:0]       in_valid,
    output logic     [NUM_INPUTS-1:0]       in_ready,
    input  wid_t     [NUM_INPUTS-1:0]       in_wid,
    input  reg_idx_t [NUM_INPUTS-1:0]       in_rd,
    input  logic     [NUM_INPUTS-1:0]       in_wb,
    input  logic     [NUM_INPUTS-1:0]       in_sop,
    input  logic     [NUM_INPUTS-1:0]       in_eop,
    input  word_t    [NUM_INPUTS-1:0]       in_data,

    output logic                            out_valid,
    output wid_t                            out_wid,
    output reg_idx_t                        out_rd,
    output logic                            out_wb,
    output logic                            out_sop,
    output logic                            out_eop,
    output word_t                           out_data
);

    localparam int SEL_W = (NUM_INPUTS > 1) ? $clog2(NUM_INPUTS) : 1;

    logic [NUM_INPUTS-1:0] grant;
    logic [SEL_W-1:0]      sel;
    logic                  any_valid;

    // pick the lowest-numbered valid input
    always_comb begin
        grant     = '0;
        sel       = '0;
        any_valid = 1'b0;
        for (int i = 0; i < NUM_INPUTS; i++) begin
            if (in_valid[i] && !any_valid) begin
                grant[i]  = 1'b1;
                sel       = SEL_W'(i);
                any_valid = 1'b1;
            end
        end
    end

    // writeback never stalls, so the grant is the ready
    assign in_ready = grant;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= any_valid;
        end
    end

    // payload only loads on a transfer
    always_ff @(posedge clk) begin
        if (any_valid) begin
            out_wid  <= in_wid[sel];
            out_rd   <= in_rd[sel];
            out_wb   <= in_wb[sel];
            out_sop  <= in_sop[sel];
            out_eop  <= in_eop[sel];
            out_data <= in_data[sel];
        end
    end

endmodule

`default_nettype wire

//--- commit_if.sv
/* commit stream from one execution unit to one issue slot
   valid/ready handshake, modports for unit and commit stage */

`default_nettype none

interface commit_if import gpu_pkg::*; ();

    logic     valid;
    logic     ready;
    wid_t     wid;
    reg_idx_t rd;
    logic     wb;
    word_t    data;
    logic     sop;
    logic     eop;

    // execution unit holds fields until valid and ready meet
    modport ex (
        output valid, wid, rd, wb, data, sop, eop,
        input  ready
    );

    modport commit (
        input  valid, wid, rd, wb, data, sop, eop,
        output ready
    );

endinterface

`default_nettype wire

//--- commit_stage.sv
/* commit stage: per-slot arbiters, writeback drive
   and the registered retire count for the scheduler */

`default_nettype none

`include "gpu_consts.svh"

module commit_stage import gpu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    commit_if.commit    commit_in [`NUM_EX_UNITS * `ISSUE_WIDTH],
    writeback_if.src    wb_out [`ISSUE_WIDTH],
    output cnt_t        retire_cnt
);

    // slots whose writeback beat ends a packet
    logic [`ISSUE_WIDTH-1:0] retire_vec;
    cnt_t                    retire_sum;

    for (genvar i = 0; i < `ISSUE_WIDTH; i++) begin : g_slot
        logic     [`NUM_EX_UNITS-1:0] valid_v;
        logic     [`NUM_EX_UNITS-1:0] ready_v;
        wid_t     [`NUM_EX_UNITS-1:0] wid_v;
        reg_idx_t [`NUM_EX_UNITS-1:0] rd_v;
        logic     [`NUM_EX_UNITS-1:0] wb_v;
        logic     [`NUM_EX_UNITS-1:0] sop_v;
        logic     [`NUM_EX_UNITS-1:0] eop_v;
        word_t    [`NUM_EX_UNITS-1:0] data_v;

        logic     arb_valid;
        wid_t     arb_wid;
        reg_idx_t arb_rd;
        logic     arb_wb;
        logic     arb_sop;
        logic     arb_eop;
        word_t    arb_data;

        // stream j*ISSUE_WIDTH+i is unit j on slot i
        for (genvar j = 0; j < `NUM_EX_UNITS; j++) begin : g_unit
            assign valid_v[j] = commit_in[j * `ISSUE_WIDTH + i].valid;
            assign wid_v[j]   = commit_in[j * `ISSUE_WIDTH + i].wid;
            assign rd_v[j]    = commit_in[j * `ISSUE_WIDTH + i].rd;
            assign wb_v[j]    = commit_in[j * `ISSUE_WIDTH + i].wb;
            assign sop_v[j]   = commit_in[j * `ISSUE_WIDTH + i].sop;
            assign eop_v[j]   = commit_in[j * `ISSUE_WIDTH + i].eop;
            assign data_v[j]  = commit_in[j * `ISSUE_WIDTH + i].data;
            assign commit_in[j * `ISSUE_WIDTH + i].ready = ready_v[j];
        end

        commit_arb #(
            .NUM_INPUTS (`NUM_EX_UNITS)
        ) arb_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (valid_v),
            .in_ready  (ready_v),
            .in_wid    (wid_v),
            .in_rd     (rd_v),
            .in_wb     (wb_v),
            .in_sop    (sop_v),
            .in_eop    (eop_v),
            .in_data   (data_v),
            .out_valid (arb_valid),
            .out_wid   (arb_wid),
            .out_rd    (arb_rd),
            .out_wb    (arb_wb),
            .out_sop   (arb_sop),
            .out_eop   (arb_eop),
            .out_data  (arb_data)
        );

        assign wb_out[i].valid = arb_valid;
        // warp w sits at index w / ISSUE_WIDTH of slot w % ISSUE_WIDTH
        assign wb_out[i].wis   = wis_t'(arb_wid / `ISSUE_WIDTH);
        assign wb_out[i].rd    = arb_rd;
        assign wb_out[i].wb    = arb_wb;
        assign wb_out[i].data  = arb_data;
        assign wb_out[i].sop   = arb_sop;
        assign wb_out[i].eop   = arb_eop;

        assign retire_vec[i] = arb_valid && arb_eop;
    end

    // popcount of retiring slots
    always_comb begin
        retire_sum = '0;
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            retire_sum = retire_sum + cnt_t'(retire_vec[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_cnt <= '0;
        end else begin
            retire_cnt <= retire_sum;
        end
    end

endmodule

`default_nettype wire

//--- commit_top.sv
/* top level of the commit path with plain ports
   maps unit streams onto interfaces, commit stage and regfile */

`default_nettype none

`include "gpu_consts.svh"

module commit_top import gpu_pkg::*; (
    input  logic                                          clk,
    input  logic                                          rst_n,

    // stream k is unit k / ISSUE_WIDTH on slot k % ISSUE_WIDTH
    input  logic     [`NUM_EX_UNITS*`ISSUE_WIDTH-1:0]     ex_valid,
    output logic     [`NUM_EX_UNITS*`ISSUE_WIDTH-1:0]     ex_ready,
    input  wid_t     [`NUM_EX_UNITS*`ISSUE_WIDTH-1:0]     ex_wid,
    input  reg_idx_t [`NUM_EX_UNITS*`ISSUE_WIDTH-1:0]     ex_rd,
    input  word_t    [`NUM_EX_UNITS*`ISSUE_WIDTH-1:0]     ex_data,
    input  logic     [`NUM_EX_UNITS*`ISSUE_WIDTH-1:0]     ex_wb,
    input  logic     [`NUM_EX_UNITS*`ISSUE_WIDTH-1:0]     ex_sop,
    input  logic     [`NUM_EX_UNITS*`ISSUE_WIDTH-1:0]     ex_eop,

    output cnt_t                                          retire_cnt,

    input  wid_t                                          rd_wid,
    input  reg_idx_t                                      rd_reg,
    output word_t                                         rd_data
);

    commit_if    ex_if [`NUM_EX_UNITS * `ISSUE_WIDTH] ();
    writeback_if wb_if [`ISSUE_WIDTH] ();

    for (genvar k = 0; k < `NUM_EX_UNITS * `ISSUE_WIDTH; k++) begin : g_stream
        assign ex_if[k].valid = ex_valid[k];
        assign ex_if[k].wid   = ex_wid[k];
        assign ex_if[k].rd    = ex_rd[k];
        assign ex_if[k].wb    = ex_wb[k];
        assign ex_if[k].data  = ex_data[k];
        assign ex_if[k].sop   = ex_sop[k];
        assign ex_if[k].eop   = ex_eop[k];
        assign ex_ready[k]    = ex_if[k].ready;
    end

    commit_stage commit_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .commit_in  (ex_if),
        .wb_out     (wb_if),
        .retire_cnt (retire_cnt)
    );

    // written registers are visible one cycle after the writeback beat
    warp_regfile regfile_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_in   (wb_if),
        .rd_wid  (rd_wid),
        .rd_reg  (rd_reg),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

//--- gpu_consts.svh
/* sizing macros for the commit stage
   execution units, issue slots, warps and registers */

`ifndef GPU_CONSTS_SVH
`define GPU_CONSTS_SVH

// execution units that feed commit, one stream per slot each
`define NUM_EX_UNITS 3

// issue slots, one arbiter and one writeback port each
`define ISSUE_WIDTH 2

// warps in the core
`define NUM_WARPS 8

// architectural registers per warp
`define NUM_REGS 32

// warps sharing one issue slot
`define WARPS_PER_SLOT (`NUM_WARPS / `ISSUE_WIDTH)

`endif

//--- gpu_pkg.sv
/* shared vector types for warp ids, in-slot indices,
   register indices, result words and retire counts */

`default_nettype none

`include "gpu_consts.svh"

package gpu_pkg;

    // field widths derived from the sizing macros
    localparam int WID_W  = $clog2(`NUM_WARPS);
    localparam int WIS_W  = $clog2(`WARPS_PER_SLOT);
    localparam int REG_W  = $clog2(`NUM_REGS);
    localparam int WORD_W = 32;

    // count must hold 0 up to ISSUE_WIDTH inclusive
    localparam int CNT_W  = $clog2(`ISSUE_WIDTH + 1);

    // warp id across the whole core
    typedef logic [WID_W-1:0]  wid_t;

    // warp index inside its issue slot
    typedef logic [WIS_W-1:0]  wis_t;

    typedef logic [REG_W-1:0]  reg_idx_t;

    // one value per result, no lanes
    typedef logic [WORD_W-1:0] word_t;

    // warps retired in one cycle
    typedef logic [CNT_W-1:0]  cnt_t;

endpackage

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build and run the commit path testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_commit -f all.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_commit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    echo "simulation reported failures"
    exit 1
fi

echo "simulation finished without failures"
exit 0

//--- tb_clock_gen.sv
/* clock and reset source for the commit path testbench */

`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // released on a falling edge, away from the active edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- tb_commit.sv
/* directed tests for the commit path with a reference
   register model, a watchdog and a summary line */

`default_nettype none

`include "gpu_consts.svh"

module tb_commit import gpu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NS       = `NUM_EX_UNITS * `ISSUE_WIDTH;
    localparam int PERIOD   = 40;
    localparam int NUM_RAND = 60;
    // reset, directed tests, random stream and its readback
    localparam int BUDGET   = 10 + 60 + 10 * NUM_RAND;

    logic              clk;
    logic              rst_n;
    logic     [NS-1:0] ex_valid;
    logic     [NS-1:0] ex_ready;
    wid_t     [NS-1:0] ex_wid;
    reg_idx_t [NS-1:0] ex_rd;
    word_t    [NS-1:0] ex_data;
    logic     [NS-1:0] ex_wb;
    logic     [NS-1:0] ex_sop;
    logic     [NS-1:0] ex_eop;
    cnt_t              retire_cnt;
    wid_t              rd_wid;
    reg_idx_t          rd_reg;
    word_t             rd_data;

    // register file mirror, indexed by global warp id
    word_t  ref_mem [`NUM_WARPS][`NUM_REGS];
    logic   touched [`NUM_WARPS][`NUM_REGS];
    integer seed;
    int     err_count;
    int     tests_run;
    int     tests_passed;

    tb_clock_gen #(.PERIOD (PERIOD), .RESET_CYCLES (10)) clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    commit_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_valid   (ex_valid),
        .ex_ready   (ex_ready),
        .ex_wid     (ex_wid),
        .ex_rd      (ex_rd),
        .ex_data    (ex_data),
        .ex_wb      (ex_wb),
        .ex_sop     (ex_sop),
        .ex_eop     (ex_eop),
        .retire_cnt (retire_cnt),
        .rd_wid     (rd_wid),
        .rd_reg     (rd_reg),
        .rd_data    (rd_data)
    );

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [NS-1:0] stream_mask(int k);
        return NS'(1) << k;
    endfunction

    // per slot, the valid stream of the lowest unit is the one granted
    function automatic logic [NS-1:0] expected_grant(logic [NS-1:0] valid);
        logic [NS-1:0] g;
        int            pick;
        g = '0;
        for (int s = 0; s < `ISSUE_WIDTH; s++) begin
            pick = -1;
            for (int u = `NUM_EX_UNITS - 1; u >= 0; u--) begin
                if (valid[u * `ISSUE_WIDTH + s]) pick = u;
            end
            if (pick >= 0) g[pick * `ISSUE_WIDTH + s] = 1'b1;
        end
        return g;
    endfunction

    task automatic report_value(string name, logic [31:0] got, logic [31:0] exp);
        $display("FAILED at time %0t: %s is %h, expected %h", $time, name, got, exp);
        err_count++;
    endtask

    task automatic end_test(string name, int start_err);
        tests_run++;
        if (err_count == start_err) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_count - start_err);
        end
    endtask

    task automatic drive_stream(int k, wid_t w, reg_idx_t r, word_t d,
                                logic wb, logic sop, logic eop);
        ex_valid[k] = 1'b1;
        ex_wid[k]   = w;
        ex_rd[k]    = r;
        ex_data[k]  = d;
        ex_wb[k]    = wb;
        ex_sop[k]   = sop;
        ex_eop[k]   = eop;
    endtask

    // only valid beats with wb set change a register
    task automatic model_write(int w, int r, word_t d, logic wb);
        if (wb) begin
            ref_mem[w][r] = d;
        end
        touched[w][r] = 1'b1;
    endtask

    // offer one item, expect it granted at once, return on the next falling edge
    task automatic send_single(int k, wid_t w, reg_idx_t r, word_t d,
                               logic wb, logic sop, logic eop);
        @(negedge clk);
        drive_stream(k, w, r, d, wb, sop, eop);
        @(posedge clk);
        if (ex_ready[k] !== 1'b1) begin
            report_value($sformatf("ex_ready[%0d]", k), 32'(ex_ready[k]), 1);
        end
        model_write(int'(w), int'(r), d, wb);
        @(negedge clk);
        ex_valid[k] = 1'b0;
    endtask

    task automatic check_reg(int w, int r);
        @(negedge clk);
        rd_wid = wid_t'(w);
        rd_reg = reg_idx_t'(r);
        #(PERIOD / 4);
        if (rd_data !== ref_mem[w][r]) begin
            report_value($sformatf("rd_data w%0d r%0d", w, r), rd_data, ref_mem[w][r]);
        end
    endtask

    task automatic test_single_write();
        int    start_err;
        word_t d;
        start_err = err_count;
        d = word_t'($random(seed));
        @(negedge clk);
        rd_wid = wid_t'(4);
        rd_reg = reg_idx_t'(7);
        // unit 1 on slot 0, warp 4 maps to slot 0
        send_single(1 * `ISSUE_WIDTH, wid_t'(4), reg_idx_t'(7), d, 1'b1, 1'b1, 1'b1);
        if (retire_cnt !== cnt_t'(0)) report_value("retire_cnt", 32'(retire_cnt), 0);
        @(negedge clk);
        if (retire_cnt !== cnt_t'(1)) report_value("retire_cnt", 32'(retire_cnt), 1);
        if (rd_data !== d) report_value("rd_data", rd_data, d);
        @(negedge clk);
        if (retire_cnt !== cnt_t'(0)) report_value("retire_cnt", 32'(retire_cnt), 0);
        end_test("single write", start_err);
    endtask

    task automatic test_priority();
        int    start_err;
        word_t a;
        word_t b;
        start_err = err_count;
        a = word_t'($random(seed));
        b = word_t'($random(seed));
        @(negedge clk);
        // units 0 and 2 both on slot 1
        drive_stream(1, wid_t'(3), reg_idx_t'(10), a, 1'b1, 1'b1, 1'b1);
        drive_stream(5, wid_t'(5), reg_idx_t'(11), b, 1'b1, 1'b1, 1'b1);
        @(posedge clk);
        if (ex_ready !== stream_mask(1)) begin
            report_value("ex_ready", 32'(ex_ready), 32'(stream_mask(1)));
        end
        model_write(3, 10, a, 1'b1);
        @(negedge clk);
        ex_valid[1] = 1'b0;
        @(posedge clk);
        if (ex_ready !== stream_mask(5)) begin
            report_value("ex_ready", 32'(ex_ready), 32'(stream_mask(5)));
        end
        model_write(5, 11, b, 1'b1);
        @(negedge clk);
        ex_valid[5] = 1'b0;
        check_reg(3, 10);
        check_reg(5, 11);
        end_test("priority", start_err);
    endtask

    task automatic test_retire_count();
        int            start_err;
        word_t         a;
        logic [NS-1:0] both;
        start_err = err_count;
        a = word_t'($random(seed));
        both = stream_mask(0) | stream_mask(3);
        @(negedge clk);
        drive_stream(0, wid_t'(2), reg_idx_t'(1), a, 1'b1, 1'b1, 1'b1);
        drive_stream(3, wid_t'(7), reg_idx_t'(2), ~a, 1'b1, 1'b1, 1'b1);
        @(posedge clk);
        if (ex_ready !== both) report_value("ex_ready", 32'(ex_ready), 32'(both));
        model_write(2, 1, a, 1'b1);
        model_write(7, 2, ~a, 1'b1);
        @(negedge clk);
        ex_valid = '0;
        if (retire_cnt !== cnt_t'(0)) report_value("retire_cnt", 32'(retire_cnt), 0);
        @(negedge clk);
        if (retire_cnt !== cnt_t'(2)) report_value("retire_cnt", 32'(retire_cnt), 2);
        // sop without eop still writes
        drive_stream(0, wid_t'(2), reg_idx_t'(5), a + 1, 1'b1, 1'b1, 1'b0);
        drive_stream(3, wid_t'(7), reg_idx_t'(6), a - 1, 1'b1, 1'b1, 1'b0);
        @(posedge clk);
        if (ex_ready !== both) report_value("ex_ready", 32'(ex_ready), 32'(both));
        model_write(2, 5, a + 1, 1'b1);
        model_write(7, 6, a - 1, 1'b1);
        repeat (2) begin
            @(negedge clk);
            ex_valid = '0;
            if (retire_cnt !== cnt_t'(0)) report_value("retire_cnt", 32'(retire_cnt), 0);
        end
        check_reg(2, 1);
        check_reg(7, 2);
        check_reg(2, 5);
        check_reg(7, 6);
        end_test("retire count", start_err);
    endtask

    task automatic test_no_write();
        int    start_err;
        word_t a;
        start_err = err_count;
        a = word_t'($random(seed));
        // unit 2 on slot 0, warp 6
        send_single(4, wid_t'(6), reg_idx_t'(20), a, 1'b1, 1'b1, 1'b0);
        send_single(4, wid_t'(6), reg_idx_t'(20), ~a, 1'b0, 1'b0, 1'b1);
        if (retire_cnt !== cnt_t'(0)) report_value("retire_cnt", 32'(retire_cnt), 0);
        @(negedge clk);
        if (retire_cnt !== cnt_t'(1)) report_value("retire_cnt", 32'(retire_cnt), 1);
        check_reg(6, 20);
        end_test("no write", start_err);
    endtask

    task automatic test_random_stream();
        int            start_err;
        int            sent;
        int            done_cnt;
        int            cnt_new;
        int            cnt_last;
        int            cnt_prev;
        int            k;
        int            w;
        int            r;
        logic [NS-1:0] fired;
        logic [NS-1:0] exp_ready;
        start_err = err_count;
        sent = 0;
        done_cnt = 0;
        cnt_last = 0;
        cnt_prev = 0;
        fired = '0;
        while (done_cnt < NUM_RAND) begin
            @(negedge clk);
            // count seen now belongs to transfers two edges back
            if (retire_cnt !== cnt_t'(cnt_prev)) begin
                report_value("retire_cnt", 32'(retire_cnt), cnt_prev);
            end
            for (k = 0; k < NS; k++) begin
                if (fired[k]) ex_valid[k] = 1'b0;
                if (!ex_valid[k] && sent < NUM_RAND && rand_below(2) == 1) begin
                    w = rand_below(`WARPS_PER_SLOT) * `ISSUE_WIDTH + k % `ISSUE_WIDTH;
                    drive_stream(k, wid_t'(w), reg_idx_t'(rand_below(`NUM_REGS)),
                                 word_t'($random(seed)), rand_below(4) != 0,
                                 rand_below(2) == 1, rand_below(2) == 1);
                    sent++;
                end
            end
            @(posedge clk);
            exp_ready = expected_grant(ex_valid);
            if (ex_ready !== exp_ready) begin
                report_value("ex_ready", 32'(ex_ready), 32'(exp_ready));
            end
            fired = ex_valid & exp_ready;
            cnt_new = 0;
            for (k = 0; k < NS; k++) begin
                if (fired[k]) begin
                    model_write(int'(ex_wid[k]), int'(ex_rd[k]), ex_data[k], ex_wb[k]);
                    cnt_new += int'(ex_eop[k]);
                    done_cnt++;
                end
            end
            cnt_prev = cnt_last;
            cnt_last = cnt_new;
        end
        @(negedge clk);
        ex_valid = ex_valid & ~fired;
        if (retire_cnt !== cnt_t'(cnt_prev)) report_value("retire_cnt", 32'(retire_cnt), cnt_prev);
        @(negedge clk);
        if (retire_cnt !== cnt_t'(cnt_last)) report_value("retire_cnt", 32'(retire_cnt), cnt_last);
        for (w = 0; w < `NUM_WARPS; w++) begin
            for (r = 0; r < `NUM_REGS; r++) begin
                if (touched[w][r]) check_reg(w, r);
            end
        end
        end_test("random stream", start_err);
    endtask

    initial begin
        seed         = 32'h3b22_03ef;
        err_count    = 0;
        tests_run    = 0;
        tests_passed = 0;
        ex_valid     = '0;
        ex_wid       = '0;
        ex_rd        = '0;
        ex_data      = '0;
        ex_wb        = '0;
        ex_sop       = '0;
        ex_eop       = '0;
        rd_wid       = '0;
        rd_reg       = '0;
        for (int w = 0; w < `NUM_WARPS; w++) begin
            for (int r = 0; r < `NUM_REGS; r++) begin
                ref_mem[w][r] = '0;
                touched[w][r] = 1'b0;
            end
        end
        wait (rst_n === 1'b1);
        test_single_write();
        test_priority();
        test_retire_count();
        test_no_write();
        test_random_stream();
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_passed, tests_run - tests_passed, err_count);
        if (err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(BUDGET * PERIOD);
        $display("watchdog expired after %0d cycles, tests did not finish", BUDGET);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

//--- warp_regfile.sv
/* banked per-warp register file, one bank per issue slot
   one write per bank per cycle, one combinational read port */

`default_nettype none

`include "gpu_consts.svh"

module warp_regfile import gpu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    writeback_if.sink   wb_in [`ISSUE_WIDTH],
    input  wid_t        rd_wid,
    input  reg_idx_t    rd_reg,
    output word_t       rd_data
);

    localparam int SLOT_W = (`ISSUE_WIDTH > 1) ? $clog2(`ISSUE_WIDTH) : 1;

    logic [SLOT_W-1:0]         rd_slot;
    wis_t                      rd_wis;
    word_t [`ISSUE_WIDTH-1:0]  bank_rd;

    // same mapping as the commit stage uses for writeback
    assign rd_slot = SLOT_W'(rd_wid % `ISSUE_WIDTH);
    assign rd_wis  = wis_t'(rd_wid / `ISSUE_WIDTH);

    for (genvar i = 0; i < `ISSUE_WIDTH; i++) begin : g_bank
        word_t mem_q [`WARPS_PER_SLOT][`NUM_REGS];
        logic  wr_en;

        assign wr_en = wb_in[i].valid && wb_in[i].wb;

        // registers read as zero after reset
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                mem_q <= '{default: '0};
            end else if (wr_en) begin
                mem_q[wb_in[i].wis][wb_in[i].rd] <= wb_in[i].data;
            end
        end

        assign bank_rd[i] = mem_q[rd_wis][rd_reg];
    end

    assign rd_data = bank_rd[rd_slot];

endmodule

`default_nettype wire

//--- writeback_if.sv
/* writeback stream from one issue slot to its register bank
   no back-pressure, the sink takes a beat every cycle */

`default_nettype none

interface writeback_if import gpu_pkg::*; ();

    logic     valid;
    wis_t     wis;
    reg_idx_t rd;
    logic     wb;
    word_t    data;
    logic     sop;
    logic     eop;

    modport src (
        output valid, wis, rd, wb, data, sop, eop
    );

    // register write needs both valid and wb
    modport sink (
        input  valid, wis, rd, wb, data, sop, eop
    );

endinterface

`default_nettype wire
